// File: lspPkg.sv
package lspPkg;

	////////////////////
	// Data types
	////////////////////

	typedef logic [10:0] memAddrT;
	typedef logic [31:0] memDataT;
	typedef logic signed [15:0] lspWordT;
	typedef logic signed [31:0] lspAccT;
	typedef logic modeIndexT;

	localparam int MEM_WORDS = 2048;
	localparam int DEFAULT_LSP_ORDER = 10;

	////////////////////
	// Scratch memory map
	////////////////////

	localparam memAddrT TARGET_BASE = 11'd0;
	localparam memAddrT QUANT_BASE0 = 11'd16;
	localparam memAddrT QUANT_BASE1 = 11'd32;
	localparam memAddrT WEGT_BASE = 11'd48;
	// Even address holds mode 0, the odd one mode 1
	localparam memAddrT TDIST_BASE = 11'd64;
	localparam memAddrT MODE_INDEX_ADDR = 11'd66;

	////////////////////
	// State machines
	////////////////////

	typedef enum logic [2:0] {
		ctrlIdle, ctrlDist0, ctrlDist1, ctrlSelect, ctrlFinish
	} ctrlStateT;

	typedef enum logic [2:0] {
		tdistIdle, tdistReadTarget, tdistReadQuant, tdistReadWeight, tdistAccumulate, tdistStore
	} tdistStateT;

	typedef enum logic [1:0] {
		selIdle, selClearMode, selReadFirst, selCompare
	} selectStateT;

endpackage

// File: lspMemBus.sv
`timescale 1ns/10ps

// One read port and one write port of the scratch memory
interface lspMemBus;
	lspPkg::memAddrT readAddr;
	lspPkg::memDataT readData;
	lspPkg::memAddrT writeAddr;
	lspPkg::memDataT writeData;
	logic writeEn;

	// Engines and the arbiter output side
	modport master (
		output readAddr,
		output writeAddr,
		output writeData,
		output writeEn,
		input readData
	);

	// Memory side, read data one cycle after the address
	modport slave (
		input readAddr,
		input writeAddr,
		input writeData,
		input writeEn,
		output readData
	);
endinterface

// File: lspArith.sv
`timescale 1ns/10ps

module lspArith (
	input lspPkg::lspWordT subInA,
	input lspPkg::lspWordT subInB,
	input lspPkg::lspWordT multA,
	input lspPkg::lspWordT multB,
	input lspPkg::lspAccT macAcc,
	input lspPkg::lspWordT macA,
	input lspPkg::lspWordT macB,
	input lspPkg::lspAccT subA,
	input lspPkg::lspAccT subB,
	output lspPkg::lspWordT subOut16,
	output lspPkg::lspWordT multOut,
	output lspPkg::lspAccT macOut,
	output lspPkg::lspAccT subOut
);

	function automatic lspPkg::lspWordT sat16(input logic signed [16:0] value);
		if (value > 17'sd32767)
			return 16'sh7fff;
		if (value < -17'sd32768)
			return 16'sh8000;
		return value[15:0];
	endfunction

	function automatic lspPkg::lspAccT sat32(input logic signed [32:0] value);
		if (value > 33'sd2147483647)
			return 32'sh7fffffff;
		if (value < -33'sd2147483648)
			return 32'sh80000000;
		return value[31:0];
	endfunction

	logic signed [16:0] subWide;
	logic signed [31:0] multProduct;
	logic signed [31:0] multShifted;
	logic signed [31:0] macProduct;
	logic signed [31:0] lMult;
	logic signed [32:0] macSum;
	logic signed [32:0] subWide32;

	// sub
	assign subWide = {subInA[15], subInA} - {subInB[15], subInB};
	assign subOut16 = sat16(subWide);

	// mult, Q15 product with floor shift
	assign multProduct = multA * multB;
	assign multShifted = multProduct >>> 15;
	assign multOut = sat16(multShifted[16:0]);

	// L_mult saturates on -1 * -1 before the add
	assign macProduct = macA * macB;
	assign lMult = (macProduct == 32'sh40000000) ? 32'sh7fffffff : (macProduct <<< 1);
	assign macSum = {macAcc[31], macAcc} + {lMult[31], lMult};
	assign macOut = sat32(macSum);

	// L_sub
	assign subWide32 = {subA[31], subA} - {subB[31], subB};
	assign subOut = sat32(subWide32);

endmodule

// File: scratchMemory.sv
`timescale 1ns/10ps

module scratchMemory (
	input logic clk,
	lspMemBus.slave mem
);

	lspPkg::memDataT storage [0:lspPkg::MEM_WORDS-1];

	// Write port
	always_ff @(posedge clk)
	begin
		if (mem.writeEn)
		begin
			storage[mem.writeAddr] <= mem.writeData;
		end
	end

	// Registered read, returns old data on a same-address write
	always_ff @(posedge clk)
	begin
		mem.readData <= storage[mem.readAddr];
	end

endmodule

// File: tdistCompute.sv
`timescale 1ns/10ps

module tdistCompute #(
	parameter int lspOrder = lspPkg::DEFAULT_LSP_ORDER
) (
	input logic clk,
	input logic reset,
	input logic start,
	input lspPkg::modeIndexT mode,
	output logic done,
	lspMemBus.master mem,
	output lspPkg::lspWordT subInA,
	output lspPkg::lspWordT subInB,
	input lspPkg::lspWordT subOut16,
	output lspPkg::lspWordT multA,
	output lspPkg::lspWordT multB,
	input lspPkg::lspWordT multOut,
	output lspPkg::lspAccT macAcc,
	output lspPkg::lspWordT macA,
	output lspPkg::lspWordT macB,
	input lspPkg::lspAccT macOut
);

	localparam int indexWidth = $clog2(lspOrder + 1);
	localparam logic [indexWidth-1:0] lastIndex = indexWidth'(lspOrder - 1);

	lspPkg::tdistStateT state;
	logic [indexWidth-1:0] coefIndex;
	lspPkg::modeIndexT modeReg;
	lspPkg::lspWordT targetReg;
	lspPkg::lspWordT diffReg;
	lspPkg::lspAccT accReg;
	lspPkg::memAddrT quantBase;
	lspPkg::memAddrT coefOffset;

	assign quantBase = modeReg ? lspPkg::QUANT_BASE1 : lspPkg::QUANT_BASE0;
	assign coefOffset = lspPkg::memAddrT'(coefIndex);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= lspPkg::tdistIdle;
			coefIndex <= '0;
		end
		else
		begin
			case (state)
				lspPkg::tdistIdle:
					if (start)
					begin
						state <= lspPkg::tdistReadTarget;
						coefIndex <= '0;
					end
				lspPkg::tdistReadTarget: state <= lspPkg::tdistReadQuant;
				lspPkg::tdistReadQuant: state <= lspPkg::tdistReadWeight;
				lspPkg::tdistReadWeight: state <= lspPkg::tdistAccumulate;
				lspPkg::tdistAccumulate:
					if (coefIndex == lastIndex)
						state <= lspPkg::tdistStore;
					else
					begin
						state <= lspPkg::tdistReadTarget;
						coefIndex <= coefIndex + 1'b1;
					end
				default: state <= lspPkg::tdistIdle;
			endcase
		end
	end

	// Datapath registers
	always_ff @(posedge clk)
	begin
		if (state == lspPkg::tdistIdle && start)
		begin
			modeReg <= mode;
			accReg <= '0;
		end
		if (state == lspPkg::tdistReadQuant)
			targetReg <= mem.readData[15:0];
		if (state == lspPkg::tdistReadWeight)
			diffReg <= subOut16;
		if (state == lspPkg::tdistAccumulate)
			accReg <= macOut;
	end

	always_comb
	begin
		mem.readAddr = '0;
		mem.writeAddr = '0;
		mem.writeData = '0;
		mem.writeEn = 1'b0;
		done = 1'b0;
		subInA = '0;
		subInB = '0;
		multA = '0;
		multB = '0;
		macAcc = '0;
		macA = '0;
		macB = '0;
		case (state)
			lspPkg::tdistReadTarget: mem.readAddr = lspPkg::TARGET_BASE + coefOffset;
			lspPkg::tdistReadQuant: mem.readAddr = quantBase + coefOffset;
			lspPkg::tdistReadWeight:
			begin
				mem.readAddr = lspPkg::WEGT_BASE + coefOffset;
				// d = target - quant, quant arrives this cycle
				subInA = targetReg;
				subInB = mem.readData[15:0];
			end
			lspPkg::tdistAccumulate:
			begin
				// acc += mult(weight, d) * d
				multA = mem.readData[15:0];
				multB = diffReg;
				macAcc = accReg;
				macA = multOut;
				macB = diffReg;
			end
			lspPkg::tdistStore:
			begin
				mem.writeAddr = {lspPkg::TDIST_BASE[10:1], modeReg};
				mem.writeData = accReg;
				mem.writeEn = 1'b1;
				done = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// File: lastSelect.sv
`timescale 1ns/10ps

module lastSelect (
	input logic clk,
	input logic reset,
	input logic start,
	input lspPkg::lspAccT subOut,
	output logic done,
	lspMemBus.master mem,
	output lspPkg::lspAccT subA,
	output lspPkg::lspAccT subB
);

	lspPkg::selectStateT state;
	lspPkg::lspAccT firstTdist;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= lspPkg::selIdle;
		else
		begin
			case (state)
				lspPkg::selIdle:
					if (start)
						state <= lspPkg::selClearMode;
				lspPkg::selClearMode: state <= lspPkg::selReadFirst;
				lspPkg::selReadFirst: state <= lspPkg::selCompare;
				default: state <= lspPkg::selIdle;
			endcase
		end
	end

	// Mode 0 distortion held for the compare
	always_ff @(posedge clk)
	begin
		if (state == lspPkg::selReadFirst)
			firstTdist <= mem.readData;
	end

	always_comb
	begin
		mem.readAddr = '0;
		mem.writeAddr = '0;
		mem.writeData = '0;
		mem.writeEn = 1'b0;
		done = 1'b0;
		subA = '0;
		subB = '0;
		case (state)
			lspPkg::selClearMode:
			begin
				// Index defaults to mode 0
				mem.writeAddr = lspPkg::MODE_INDEX_ADDR;
				mem.writeEn = 1'b1;
				mem.readAddr = {lspPkg::TDIST_BASE[10:1], 1'b0};
			end
			lspPkg::selReadFirst: mem.readAddr = {lspPkg::TDIST_BASE[10:1], 1'b1};
			lspPkg::selCompare:
			begin
				subA = mem.readData;
				subB = firstTdist;
				// Negative tdist[1] - tdist[0] means mode 1 wins, a tie keeps 0
				if (subOut[31])
				begin
					mem.writeAddr = lspPkg::MODE_INDEX_ADDR;
					mem.writeData = 32'd1;
					mem.writeEn = 1'b1;
				end
				done = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// File: lspModeSelectCtrl.sv
`timescale 1ns/10ps

module lspModeSelectCtrl #(
	parameter int lspOrder = lspPkg::DEFAULT_LSP_ORDER
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic hostWriteEn,
	input lspPkg::memAddrT hostAddr,
	input lspPkg::memDataT hostWriteData,
	input logic tdistDone,
	input logic selectDone,
	output logic done,
	output logic busy,
	output logic tdistStart,
	output lspPkg::modeIndexT tdistMode,
	output logic selectStart,
	output lspPkg::memDataT hostReadData,
	lspMemBus.slave tdistMem,
	lspMemBus.slave selectMem,
	lspMemBus.master mem
);

	lspPkg::ctrlStateT state;

	assign busy = (state == lspPkg::ctrlDist0) || (state == lspPkg::ctrlDist1)
		|| (state == lspPkg::ctrlSelect);
	assign done = (state == lspPkg::ctrlFinish);

	////////////////////
	// Stage sequencer
	////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= lspPkg::ctrlIdle;
			tdistStart <= 1'b0;
			tdistMode <= 1'b0;
			selectStart <= 1'b0;
		end
		else
		begin
			tdistStart <= 1'b0;
			selectStart <= 1'b0;
			case (state)
				lspPkg::ctrlIdle:
					if (start)
					begin
						state <= lspPkg::ctrlDist0;
						tdistStart <= 1'b1;
						tdistMode <= 1'b0;
					end
				lspPkg::ctrlDist0:
					if (tdistDone)
					begin
						state <= lspPkg::ctrlDist1;
						tdistStart <= 1'b1;
						tdistMode <= 1'b1;
					end
				lspPkg::ctrlDist1:
					if (tdistDone)
					begin
						state <= lspPkg::ctrlSelect;
						selectStart <= 1'b1;
					end
				lspPkg::ctrlSelect:
					if (selectDone)
						state <= lspPkg::ctrlFinish;
				default: state <= lspPkg::ctrlIdle;
			endcase
		end
	end

	////////////////////
	// Memory arbiter
	////////////////////

	always_comb
	begin
		mem.readAddr = hostAddr;
		mem.writeAddr = hostAddr;
		mem.writeData = hostWriteData;
		mem.writeEn = hostWriteEn && !busy;
		case (state)
			lspPkg::ctrlDist0, lspPkg::ctrlDist1:
			begin
				mem.readAddr = tdistMem.readAddr;
				mem.writeAddr = tdistMem.writeAddr;
				mem.writeData = tdistMem.writeData;
				mem.writeEn = tdistMem.writeEn;
			end
			lspPkg::ctrlSelect:
			begin
				mem.readAddr = selectMem.readAddr;
				mem.writeAddr = selectMem.writeAddr;
				mem.writeData = selectMem.writeData;
				mem.writeEn = selectMem.writeEn;
			end
			default: ;
		endcase
	end

	// Read data fans out to every requester
	assign tdistMem.readData = mem.readData;
	assign selectMem.readData = mem.readData;
	assign hostReadData = mem.readData;

endmodule

// File: lspModeSelect.sv
`timescale 1ns/10ps

module lspModeSelect #(
	parameter int lspOrder = lspPkg::DEFAULT_LSP_ORDER
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic hostWriteEn,
	input lspPkg::memAddrT hostAddr,
	input lspPkg::memDataT hostWriteData,
	output logic done,
	output logic busy,
	output lspPkg::memDataT hostReadData
);

	lspMemBus tdistBus ();
	lspMemBus selectBus ();
	lspMemBus memBus ();

	logic tdistStart;
	logic tdistDone;
	lspPkg::modeIndexT tdistMode;
	logic selectStart;
	logic selectDone;

	// Operator unit wiring
	lspPkg::lspWordT subInA;
	lspPkg::lspWordT subInB;
	lspPkg::lspWordT subOut16;
	lspPkg::lspWordT multA;
	lspPkg::lspWordT multB;
	lspPkg::lspWordT multOut;
	lspPkg::lspAccT macAcc;
	lspPkg::lspWordT macA;
	lspPkg::lspWordT macB;
	lspPkg::lspAccT macOut;
	lspPkg::lspAccT subA;
	lspPkg::lspAccT subB;
	lspPkg::lspAccT subOut;

	lspModeSelectCtrl #(.lspOrder(lspOrder)) ctrl (
		.clk(clk), .reset(reset), .start(start),
		.hostWriteEn(hostWriteEn), .hostAddr(hostAddr), .hostWriteData(hostWriteData),
		.tdistDone(tdistDone), .selectDone(selectDone),
		.done(done), .busy(busy),
		.tdistStart(tdistStart), .tdistMode(tdistMode), .selectStart(selectStart),
		.hostReadData(hostReadData),
		.tdistMem(tdistBus.slave), .selectMem(selectBus.slave), .mem(memBus.master)
	);

	tdistCompute #(.lspOrder(lspOrder)) tdist (
		.clk(clk), .reset(reset), .start(tdistStart), .mode(tdistMode),
		.done(tdistDone), .mem(tdistBus.master),
		.subInA(subInA), .subInB(subInB), .subOut16(subOut16),
		.multA(multA), .multB(multB), .multOut(multOut),
		.macAcc(macAcc), .macA(macA), .macB(macB), .macOut(macOut)
	);

	lastSelect select (
		.clk(clk), .reset(reset), .start(selectStart), .subOut(subOut),
		.done(selectDone), .mem(selectBus.master), .subA(subA), .subB(subB)
	);

	lspArith arith (
		.subInA(subInA), .subInB(subInB), .multA(multA), .multB(multB),
		.macAcc(macAcc), .macA(macA), .macB(macB), .subA(subA), .subB(subB),
		.subOut16(subOut16), .multOut(multOut), .macOut(macOut), .subOut(subOut)
	);

	scratchMemory memory (
		.clk(clk), .mem(memBus.slave)
	);

endmodule

// File: lspModeSelectAsserts.sv
`timescale 1ns/10ps

module lspModeSelectAsserts (
	input logic clk,
	input logic reset,
	input logic done,
	input logic busy,
	input logic memWriteEn,
	input lspPkg::memAddrT memWriteAddr,
	input logic tdistStart,
	input logic selectStart
);

	// Single-cycle done pulse
	doneOneCycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("done stayed high for more than one cycle");

	// While busy only the engine result words may change
	noHostWriteBusy: assert property (@(posedge clk) disable iff (reset)
		(busy && memWriteEn) |-> (memWriteAddr == lspPkg::TDIST_BASE
			|| memWriteAddr == lspPkg::TDIST_BASE + 11'd1
			|| memWriteAddr == lspPkg::MODE_INDEX_ADDR))
		else $error("memory write to address %0d while busy", memWriteAddr);

	// One engine start at a time
	oneEngineStart: assert property (@(posedge clk) disable iff (reset)
		!(tdistStart && selectStart))
		else $error("both engines started in the same cycle");

endmodule

bind lspModeSelectCtrl lspModeSelectAsserts ctrlAsserts (
	.clk(clk),
	.reset(reset),
	.done(done),
	.busy(busy),
	.memWriteEn(mem.writeEn),
	.memWriteAddr(mem.writeAddr),
	.tdistStart(tdistStart),
	.selectStart(selectStart)
);

// File: lspModeSelectTb.sv
`timescale 1ns/10ps

module lspModeSelectTb;

	localparam int lspOrder = 10;
	localparam int clkPeriod = 4;
	localparam int runCycles = 8 * lspOrder + 9;
	localparam int doneLimit = runCycles + 50;
	localparam int testCount = 6;
	// Per test a vector load, one run and the read back, plus margin
	localparam int watchdogCycles = testCount * (runCycles + 4 * lspOrder + 100);

	logic clk;
	logic reset;
	logic start;
	logic hostWriteEn;
	lspPkg::memAddrT hostAddr;
	lspPkg::memDataT hostWriteData;
	logic done;
	logic busy;
	lspPkg::memDataT hostReadData;

	int checkErrors = 0;
	int otherErrors = 0;
	logic [31:0] rngState = 32'd19079;

	// Vectors, one entry per coefficient
	int targetVec [lspOrder];
	int quantVec [2][lspOrder];
	int weightVec [lspOrder];

	lspModeSelect #(.lspOrder(lspOrder)) dut (
		.clk(clk), .reset(reset), .start(start),
		.hostWriteEn(hostWriteEn), .hostAddr(hostAddr), .hostWriteData(hostWriteData),
		.done(done), .busy(busy), .hostReadData(hostReadData)
	);

	always #(clkPeriod / 2) clk = ~clk;

	////////////////////
	// Random numbers
	////////////////////

	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	function automatic int randRange(input int low, input int span);
		return low + int'(nextRandom() % 32'(span));
	endfunction

	// Magnitude in [spread, 2*spread), either sign
	function automatic int randOffset(input int spread);
		int magnitude;
		magnitude = randRange(spread, spread);
		return nextRandom() & 1 ? magnitude : -magnitude;
	endfunction

	////////////////////
	// Reference model
	////////////////////

	function automatic int satWord(input int value);
		if (value > 32767)
			return 32767;
		if (value < -32768)
			return -32768;
		return value;
	endfunction

	function automatic longint satLong(input longint value);
		if (value > 64'sd2147483647)
			return 64'sd2147483647;
		if (value < -64'sd2147483648)
			return -64'sd2147483648;
		return value;
	endfunction

	// Sum of mult(w, d) * d, doubled and saturated like L_mac
	function automatic lspPkg::lspAccT modelTdist(input lspPkg::modeIndexT mode);
		longint acc;
		longint term;
		int diff;
		int weighted;
		acc = 0;
		for (int i = 0; i < lspOrder; i++)
		begin
			diff = satWord(targetVec[i] - quantVec[mode][i]);
			weighted = satWord((weightVec[i] * diff) >>> 15);
			term = 2 * longint'(weighted) * longint'(diff);
			if (term > 64'sd2147483647)
				term = 64'sd2147483647;
			acc = satLong(acc + term);
		end
		return lspPkg::lspAccT'(acc);
	endfunction

	////////////////////
	// Checks
	////////////////////

	task automatic checkTdist(input string testName, input lspPkg::lspAccT expected,
		input lspPkg::lspAccT actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: expected tdist %0d, actual %0d", testName, expected, actual);
			checkErrors++;
		end
	endtask

	task automatic checkMode(input string testName, input lspPkg::modeIndexT expected,
		input lspPkg::modeIndexT actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: expected mode %0d, actual %0d", testName, expected, actual);
			checkErrors++;
		end
	endtask

	task automatic checkWord(input string testName, input lspPkg::memDataT expected,
		input lspPkg::memDataT actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: expected word %h, actual %h", testName, expected, actual);
			checkErrors++;
		end
	endtask

	////////////////////
	// Host and run tasks
	////////////////////

	task automatic hostWrite(input lspPkg::memAddrT addr, input lspPkg::memDataT data);
		@(posedge clk);
		hostWriteEn <= 1'b1;
		hostAddr <= addr;
		hostWriteData <= data;
	endtask

	task automatic hostIdle();
		@(posedge clk);
		hostWriteEn <= 1'b0;
	endtask

	task automatic hostRead(input lspPkg::memAddrT addr, output lspPkg::memDataT data);
		@(posedge clk);
		hostAddr <= addr;
		@(posedge clk);
		@(negedge clk);
		data = hostReadData;
	endtask

	task automatic makeVectors(input int spread0, input int spread1);
		for (int i = 0; i < lspOrder; i++)
		begin
			targetVec[i] = randRange(-8000, 16000);
			weightVec[i] = randRange(2000, 28000);
			quantVec[0][i] = targetVec[i] + randOffset(spread0);
			quantVec[1][i] = targetVec[i] + randOffset(spread1);
		end
	endtask

	task automatic loadVectors();
		for (int i = 0; i < lspOrder; i++)
		begin
			hostWrite(lspPkg::TARGET_BASE + lspPkg::memAddrT'(i), lspPkg::memDataT'(targetVec[i]));
			hostWrite(lspPkg::QUANT_BASE0 + lspPkg::memAddrT'(i), lspPkg::memDataT'(quantVec[0][i]));
			hostWrite(lspPkg::QUANT_BASE1 + lspPkg::memAddrT'(i), lspPkg::memDataT'(quantVec[1][i]));
			hostWrite(lspPkg::WEGT_BASE + lspPkg::memAddrT'(i), lspPkg::memDataT'(weightVec[i]));
		end
		hostIdle();
	endtask

	task automatic pulseStart();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	// Cycles counted from the start cycle; elapsed covers edges already passed
	task automatic waitDone(input string testName, input int elapsed);
		int cycles;
		logic seen;
		logic busyLow;
		cycles = elapsed;
		seen = 1'b0;
		busyLow = 1'b0;
		while (!seen && cycles < elapsed + doneLimit)
		begin
			@(negedge clk);
			cycles++;
			if (done)
				seen = 1'b1;
			else if (!busy)
				busyLow = 1'b1;
		end
		if (!seen)
		begin
			$display("%s: no done pulse within %0d cycles of start", testName, doneLimit);
			otherErrors++;
		end
		else
		begin
			if (cycles != runCycles)
			begin
				$display("%s: done came %0d cycles after start instead of %0d", testName, cycles,
					runCycles);
				otherErrors++;
			end
			if (busyLow)
			begin
				$display("%s: busy dropped before done", testName);
				otherErrors++;
			end
			if (busy)
			begin
				$display("%s: busy still high in the done cycle", testName);
				otherErrors++;
			end
		end
	endtask

	task automatic checkResults(input string testName, input lspPkg::modeIndexT expectedMode);
		lspPkg::memDataT word;
		hostRead(lspPkg::TDIST_BASE, word);
		checkTdist({testName, " tdist0"}, modelTdist(1'b0), lspPkg::lspAccT'(word));
		hostRead(lspPkg::TDIST_BASE + 11'd1, word);
		checkTdist({testName, " tdist1"}, modelTdist(1'b1), lspPkg::lspAccT'(word));
		hostRead(lspPkg::MODE_INDEX_ADDR, word);
		checkMode(testName, expectedMode, lspPkg::modeIndexT'(word[0]));
	endtask

	task automatic runAndCheck(input string testName, input lspPkg::modeIndexT expectedMode);
		pulseStart();
		waitDone(testName, 0);
		checkResults(testName, expectedMode);
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic testModeOneCloser();
		makeVectors(1500, 40);
		loadVectors();
		runAndCheck("modeOneCloser", 1'b1);
	endtask

	task automatic testModeZeroAndTie();
		makeVectors(40, 1500);
		loadVectors();
		runAndCheck("modeZeroCloser", 1'b0);
		for (int i = 0; i < lspOrder; i++)
			quantVec[1][i] = quantVec[0][i];
		loadVectors();
		runAndCheck("tieKeepsZero", 1'b0);
	endtask

	// Opposite extremes overflow sub16 and the accumulator for mode 0
	task automatic testSaturation();
		lspPkg::memDataT word;
		for (int i = 0; i < lspOrder; i++)
		begin
			targetVec[i] = (i % 2 == 0) ? 32767 : -32768;
			quantVec[0][i] = (i % 2 == 0) ? -32768 : 32767;
			quantVec[1][i] = (i % 2 == 0) ? 32667 : -32668;
			weightVec[i] = 32767;
		end
		loadVectors();
		runAndCheck("saturation", 1'b1);
		hostRead(lspPkg::TDIST_BASE, word);
		checkTdist("saturation limit", 32'sh7fffffff, lspPkg::lspAccT'(word));
	endtask

	task automatic testDoneTiming();
		makeVectors(800, 200);
		loadVectors();
		pulseStart();
		waitDone("doneTiming", 0);
		@(negedge clk);
		if (done || busy)
		begin
			$display("doneTiming: done or busy high in the cycle after done");
			otherErrors++;
		end
		checkResults("doneTiming", 1'b1);
	endtask

	task automatic testBusyIgnored();
		lspPkg::memDataT word;
		makeVectors(1500, 40);
		loadVectors();
		pulseStart();
		repeat (5) @(posedge clk);
		// Restart and overwrite attempts mid-run
		for (int k = 0; k < 4; k++)
		begin
			@(posedge clk);
			start <= 1'b1;
			hostWriteEn <= 1'b1;
			hostAddr <= lspPkg::TARGET_BASE + lspPkg::memAddrT'(k);
			hostWriteData <= 32'h5a5a0000 + k;
		end
		@(posedge clk);
		start <= 1'b0;
		hostWriteEn <= 1'b0;
		waitDone("busyIgnored", 10);
		checkResults("busyIgnored", 1'b1);
		for (int k = 0; k < lspOrder; k++)
		begin
			hostRead(lspPkg::TARGET_BASE + lspPkg::memAddrT'(k), word);
			checkWord("busyIgnored target", lspPkg::memDataT'(targetVec[k]), word);
		end
	endtask

	task automatic testStaleIndex();
		lspPkg::memDataT word;
		makeVectors(40, 1500);
		loadVectors();
		hostWrite(lspPkg::MODE_INDEX_ADDR, 32'd1);
		hostIdle();
		hostRead(lspPkg::MODE_INDEX_ADDR, word);
		checkWord("staleIndex preload", 32'd1, word);
		runAndCheck("staleIndex", 1'b0);
	endtask

	////////////////////
	// Main sequence and watchdog
	////////////////////

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		hostWriteEn = 1'b0;
		hostAddr = '0;
		hostWriteData = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		testModeOneCloser();
		testModeZeroAndTie();
		testSaturation();
		testDoneTiming();
		testBusyIgnored();
		testStaleIndex();
		$display("Errors: %0d failed checks, %0d other failures", checkErrors, otherErrors);
		if (checkErrors == 0 && otherErrors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin
		#(watchdogCycles * clkPeriod);
		$display("Watchdog expired after %0d cycles, the tests did not finish", watchdogCycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: build.f
lspPkg.sv
lspMemBus.sv
lspArith.sv
scratchMemory.sv
tdistCompute.sv
lastSelect.sv
lspModeSelectCtrl.sv
lspModeSelect.sv
lspModeSelectAsserts.sv
lspModeSelectTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the mode-select testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module lspModeSelectTb -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi

if grep -qx "Simulation completed successfully" sim.log; then
	exit 0
fi
exit 1
